// ==== source/edpPkg.sv ====
package edpPkg;

  localparam int wordBits = 36;
  localparam int halfBits = 18;
  localparam int shiftCountBits = 6;

  // Bit 0 is the sign and most significant bit
  typedef logic [0:wordBits-1] word;

  typedef enum logic [1:0] {
    adaAR,
    adaARX,
    adaMQ,
    adaZero
  } adaSelT;

  typedef enum logic [1:0] {
    adbFM,
    adbBRx2,
    adbBR,
    adbARx4
  } adbSelT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassA,
    aluPassB
  } aluFuncT;

  // Shared by the AR and ARX load muxes
  typedef enum logic [2:0] {
    arCache,
    arAD,
    arEbus,
    arADX,
    arMQ,
    arFM,
    arZero
  } arSrcT;

  // Universal shift register functions
  typedef enum logic [1:0] {
    mqLoad,
    mqShl,
    mqShr,
    mqHold
  } mqFuncT;

  typedef enum logic [2:0] {
    diagAR,
    diagBR,
    diagMQ,
    diagFM,
    diagBRX,
    diagARX,
    diagADX,
    diagAD
  } diagSelT;

endpackage

// ==== source/edpControl.sv ====
`timescale 1ns/1ns

module edpControl (
  input  logic CLK,
  input  logic arstN,
  input  logic execute,
  input  edpPkg::adaSelT adaSel,
  input  edpPkg::adbSelT adbSel,
  input  edpPkg::aluFuncT aluFunc,
  input  edpPkg::arSrcT arSrc,
  input  logic arLoadLeft,
  input  logic arLoadRight,
  input  logic arxLoad,
  input  logic brLoad,
  input  logic brxLoad,
  input  edpPkg::mqFuncT mqFunc,
  input  logic [edpPkg::shiftCountBits-1:0] shiftCount,
  input  logic fmWriteLeft,
  input  logic fmWriteRight,
  input  logic longAdd,
  input  logic carryIn,
  output logic busy,
  output logic done,
  output logic arLoadL,
  output logic arLoadR,
  output logic arxLoadEn,
  output logic brLoadEn,
  output logic brxLoadEn,
  output edpPkg::mqFuncT mqOp,
  output logic fmWeL,
  output logic fmWeR,
  output edpPkg::adaSelT curAdaSel,
  output edpPkg::adbSelT curAdbSel,
  output edpPkg::aluFuncT curAluFunc,
  output logic adxCarryIn,
  output logic adChainEn
);
  import edpPkg::*;

  logic accept;
  logic isShift;
  logic shiftStart;
  logic [shiftCountBits-1:0] stepsLeft;
  mqFuncT heldMqFunc;
  adaSelT heldAdaSel;
  adbSelT heldAdbSel;
  aluFuncT heldAluFunc;
  logic heldLongAdd;
  logic heldCarryIn;

  // A new microword is taken only when no shift is running
  assign accept = execute && !busy;
  assign isShift = (mqFunc == mqShl) || (mqFunc == mqShr);
  assign shiftStart = accept && isShift && (shiftCount != '0);

  assign arLoadL = accept && arLoadLeft;
  assign arLoadR = accept && arLoadRight;
  assign arxLoadEn = accept && arxLoad;
  assign brLoadEn = accept && brLoad;
  assign brxLoadEn = accept && brxLoad;
  assign fmWeL = accept && fmWriteLeft;
  assign fmWeR = accept && fmWriteRight;

  // MQ sits still on the accepting edge of a shift microword
  always_comb begin
    if (busy) begin
      mqOp = heldMqFunc;
    end else if (accept && !isShift) begin
      mqOp = mqFunc;
    end else begin
      mqOp = mqHold;
    end
  end

  // ALU setup stays frozen while shifting so the fill bit is stable
  assign curAdaSel = busy ? heldAdaSel : adaSel;
  assign curAdbSel = busy ? heldAdbSel : adbSel;
  assign curAluFunc = busy ? heldAluFunc : aluFunc;
  assign adChainEn = busy ? heldLongAdd : longAdd;
  assign adxCarryIn = busy ? heldCarryIn : carryIn;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
      done <= 1'b0;
      stepsLeft <= '0;
      heldMqFunc <= mqLoad;
      heldAdaSel <= adaAR;
      heldAdbSel <= adbFM;
      heldAluFunc <= aluAdd;
      heldLongAdd <= 1'b0;
      heldCarryIn <= 1'b0;
    end else if (shiftStart) begin
      busy <= 1'b1;
      done <= (shiftCount == 1);
      stepsLeft <= shiftCount;
      heldMqFunc <= mqFunc;
      heldAdaSel <= adaSel;
      heldAdbSel <= adbSel;
      heldAluFunc <= aluFunc;
      heldLongAdd <= longAdd;
      heldCarryIn <= carryIn;
    end else if (busy) begin
      stepsLeft <= stepsLeft - 1'b1;
      // done lines up with the cycle of the last shift
      done <= (stepsLeft == 2);
      if (stepsLeft == 1) begin
        busy <= 1'b0;
      end
    end
  end

  arSrcKnown: assert property (@(posedge CLK) disable iff (!arstN)
    execute |-> !$isunknown(arSrc));

  // done closes a shift run and busy drops right after it
  doneEndsBusy: assert property (@(posedge CLK) disable iff (!arstN)
    done |-> busy ##1 !busy);

endmodule

// ==== source/operandMux.sv ====
`timescale 1ns/1ns

module operandMux (
  input  edpPkg::adaSelT adaSel,
  input  edpPkg::adbSelT adbSel,
  input  edpPkg::word ar,
  input  edpPkg::word arx,
  input  edpPkg::word br,
  input  edpPkg::word brx,
  input  edpPkg::word mq,
  input  edpPkg::word fm,
  output edpPkg::word ada,
  output logic [0:edpPkg::wordBits+1] adb,
  output edpPkg::word adxa,
  output edpPkg::word adxb
);
  import edpPkg::*;

  always_comb begin
    case (adaSel)
      adaAR:   ada = ar;
      adaARX:  ada = arx;
      adaMQ:   ada = mq;
      default: ada = '0;
    endcase
    // Low word follows the zero select and is ARX otherwise
    adxa = (adaSel == adaZero) ? '0 : arx;
  end

  // First two ADB bits form the extension from sign or shifted-out bits
  always_comb begin
    case (adbSel)
      adbFM: begin
        adb = {fm[0], fm[0], fm};
        adxb = '0;
      end
      adbBRx2: begin
        adb = {br[0], br[0], br[1:wordBits-1], brx[0]};
        adxb = {brx[1:wordBits-1], 1'b0};
      end
      adbBR: begin
        adb = {br[0], br[0], br};
        adxb = brx;
      end
      default: begin
        // Times four moves AR:ARX up two places
        adb = {ar[0], ar[1], ar[2:wordBits-1], arx[0:1]};
        adxb = {arx[2:wordBits-1], 2'b00};
      end
    endcase
  end

endmodule

// ==== source/lookaheadAlu.sv ====
`timescale 1ns/1ns

module lookaheadAlu #(
  parameter int width = 36
) (
  input  edpPkg::aluFuncT func,
  input  logic [0:width-1] a,
  input  logic [0:width-1] b,
  input  logic carryIn,
  output logic [0:width-1] result,
  output logic carryOut,
  output logic overflow
);
  import edpPkg::*;

  localparam int groupBits = 6;
  localparam int groups = (width + groupBits - 1) / groupBits;
  localparam int paddedBits = groups * groupBits;

  // Working vectors are LSB first
  // Padding bits never generate or propagate
  logic [paddedBits-1:0] genL;
  logic [paddedBits-1:0] propL;
  logic [paddedBits-1:0] carryL;
  logic [groups-1:0] grpGen;
  logic [groups-1:0] grpProp;
  logic [groups-1:0] grpCarry;
  logic [0:width-1] sum;
  logic arith;
  logic cin;

  assign arith = (func == aluAdd) || (func == aluSub);
  assign cin = (func == aluSub) ? 1'b1 : carryIn;

  always_comb begin
    logic bBit;
    genL = '0;
    propL = '0;
    for (int j = 0; j < width; j++) begin
      bBit = (func == aluSub) ? ~b[width-1-j] : b[width-1-j];
      genL[j] = a[width-1-j] & bBit;
      propL[j] = a[width-1-j] ^ bBit;
    end
  end

  // Six-bit group generate and propagate
  always_comb begin
    int idx;
    for (int k = 0; k < groups; k++) begin
      grpGen[k] = 1'b0;
      grpProp[k] = 1'b1;
      for (int j = 0; j < groupBits; j++) begin
        idx = k * groupBits + j;
        grpGen[k] = genL[idx] | (propL[idx] & grpGen[k]);
        grpProp[k] = grpProp[k] & propL[idx];
      end
    end
  end

  // Each group carry from lower group terms and the carry in only
  always_comb begin
    for (int k = 0; k < groups; k++) begin
      grpCarry[k] = cin;
      for (int m = 0; m < k; m++) begin
        grpCarry[k] = grpGen[m] | (grpProp[m] & grpCarry[k]);
      end
    end
  end

  always_comb begin
    logic c;
    for (int k = 0; k < groups; k++) begin
      c = grpCarry[k];
      for (int j = 0; j < groupBits; j++) begin
        carryL[k * groupBits + j] = c;
        c = genL[k * groupBits + j] | (propL[k * groupBits + j] & c);
      end
    end
  end

  always_comb begin
    for (int j = 0; j < width; j++) begin
      sum[width-1-j] = propL[j] ^ carryL[j];
    end
  end

  always_comb begin
    case (func)
      aluAdd, aluSub: result = sum;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluPassA: result = a;
      aluPassB: result = b;
      default:  result = '0;
    endcase
  end

  // Flags refer to the 36-bit word
  // Its sign is LSB-first bit wordBits-1
  assign carryOut = arith & (genL[wordBits-1] | (propL[wordBits-1] & carryL[wordBits-1]));
  assign overflow = arith & (carryOut ^ carryL[wordBits-1]);

endmodule

// ==== source/workRegs.sv ====
`timescale 1ns/1ns

module workRegs (
  input  logic CLK,
  input  logic arstN,
  input  logic arLoadL,
  input  logic arLoadR,
  input  edpPkg::arSrcT arSrc,
  input  logic arxLoadEn,
  input  edpPkg::arSrcT arxSrc,
  input  logic brLoadEn,
  input  logic brxLoadEn,
  input  edpPkg::word cacheData,
  input  edpPkg::word ebusData,
  input  edpPkg::word ad,
  input  edpPkg::word adx,
  input  edpPkg::word mq,
  input  edpPkg::word fm,
  output edpPkg::word ar,
  output edpPkg::word arx,
  output edpPkg::word br,
  output edpPkg::word brx
);
  import edpPkg::*;

  word sources [0:7];
  word arData;
  word arxData;

  // One source table serves both the AR and ARX muxes
  always_comb begin
    sources[arCache] = cacheData;
    sources[arAD] = ad;
    sources[arEbus] = ebusData;
    sources[arADX] = adx;
    sources[arMQ] = mq;
    sources[arFM] = fm;
    sources[arZero] = '0;
    sources[7] = '0;
  end

  assign arData = sources[arSrc];
  assign arxData = sources[arxSrc];

  // Halves load separately; arZero with one strobe clears just that half
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ar <= '0;
    end else begin
      if (arLoadL) begin
        ar[0:halfBits-1] <= arData[0:halfBits-1];
      end
      if (arLoadR) begin
        ar[halfBits:wordBits-1] <= arData[halfBits:wordBits-1];
      end
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      arx <= '0;
    end else if (arxLoadEn) begin
      arx <= arxData;
    end
  end

  // BR and BRX only ever take a copy of AR and ARX
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      br <= '0;
      brx <= '0;
    end else begin
      if (brLoadEn) begin
        br <= ar;
      end
      if (brxLoadEn) begin
        brx <= arx;
      end
    end
  end

endmodule

// ==== source/mqShifter.sv ====
`timescale 1ns/1ns

module mqShifter (
  input  logic CLK,
  input  logic arstN,
  input  edpPkg::mqFuncT mqOp,
  input  edpPkg::word loadValue,
  input  logic shiftInBit,
  output edpPkg::word mq
);
  import edpPkg::*;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      mq <= '0;
    end else begin
      case (mqOp)
        mqLoad: mq <= loadValue;
        // Low end filled from the AD carry
        mqShl:  mq <= {mq[1:wordBits-1], shiftInBit};
        // Bit 0 stays, bit 1 is kept and copied down as the sign
        mqShr:  mq <= {mq[0], mq[1], mq[1:wordBits-2]};
        default: mq <= mq;
      endcase
    end
  end

  mqOpKnown: assert property (@(posedge CLK) disable iff (!arstN)
    !$isunknown(mqOp));

endmodule

// ==== source/fastMem.sv ====
`timescale 1ns/1ns

module fastMem #(
  parameter int fmAddrBits = 4
) (
  input  logic CLK,
  input  logic [fmAddrBits-1:0] fmAddr,
  input  logic fmWeL,
  input  logic fmWeR,
  input  edpPkg::word writeData,
  output edpPkg::word fm,
  output logic fmParity
);
  import edpPkg::*;

  word mem [0:(1 << fmAddrBits) - 1];

  // Halfword enables, each covers its own 18 bits
  always_ff @(posedge CLK) begin
    if (fmWeL) begin
      mem[fmAddr][0:halfBits-1] <= writeData[0:halfBits-1];
    end
    if (fmWeR) begin
      mem[fmAddr][halfBits:wordBits-1] <= writeData[halfBits:wordBits-1];
    end
  end

  // Asynchronous read
  assign fm = mem[fmAddr];
  assign fmParity = ^fm;

endmodule

// ==== source/edpTop.sv ====
`timescale 1ns/1ns

module edpTop #(
  parameter int fmAddrBits = 4
) (
  input  logic CLK,
  input  logic arstN,
  input  logic execute,
  input  edpPkg::adaSelT adaSel,
  input  edpPkg::adbSelT adbSel,
  input  edpPkg::aluFuncT aluFunc,
  input  edpPkg::arSrcT arSrc,
  input  logic arLoadLeft,
  input  logic arLoadRight,
  input  edpPkg::arSrcT arxSrc,
  input  logic arxLoad,
  input  logic brLoad,
  input  logic brxLoad,
  input  edpPkg::mqFuncT mqFunc,
  input  logic [edpPkg::shiftCountBits-1:0] shiftCount,
  input  logic [fmAddrBits-1:0] fmAddr,
  input  logic fmWriteLeft,
  input  logic fmWriteRight,
  input  logic longAdd,
  input  logic carryIn,
  input  edpPkg::diagSelT diagSel,
  input  logic diagRead,
  input  edpPkg::word cacheData,
  input  edpPkg::word ebusData,
  output edpPkg::word adResult,
  output logic adOverflow,
  output logic carryOut,
  output logic fmParity,
  output edpPkg::word diagData,
  output logic busy,
  output logic done
);
  import edpPkg::*;

  word ar, arx, br, brx, mq, fm, ada, adxa, adxb, adx;
  logic [0:wordBits+1] adb;
  logic [0:wordBits+1] adFull;
  logic arLoadL, arLoadR, arxLoadEn, brLoadEn, brxLoadEn, fmWeL, fmWeR;
  logic adxCarryIn, adChainEn, adxCarryOut, adCarryIn;
  mqFuncT mqOp;
  adaSelT curAdaSel;
  adbSelT curAdbSel;
  aluFuncT curAluFunc;

  edpControl control (.CLK, .arstN, .execute, .adaSel, .adbSel, .aluFunc, .arSrc,
    .arLoadLeft, .arLoadRight, .arxLoad, .brLoad, .brxLoad, .mqFunc, .shiftCount,
    .fmWriteLeft, .fmWriteRight, .longAdd, .carryIn, .busy, .done, .arLoadL,
    .arLoadR, .arxLoadEn, .brLoadEn, .brxLoadEn, .mqOp, .fmWeL, .fmWeR, .curAdaSel,
    .curAdbSel, .curAluFunc, .adxCarryIn, .adChainEn);

  workRegs regs (.CLK, .arstN, .arLoadL, .arLoadR, .arSrc, .arxLoadEn, .arxSrc,
    .brLoadEn, .brxLoadEn, .cacheData, .ebusData, .ad(adResult), .adx, .mq, .fm,
    .ar, .arx, .br, .brx);

  // Left shift fill comes from the AD carry out
  mqShifter mqReg (.CLK, .arstN, .mqOp, .loadValue(adResult), .shiftInBit(carryOut), .mq);

  fastMem #(.fmAddrBits(fmAddrBits)) fmem (.CLK, .fmAddr, .fmWeL, .fmWeR,
    .writeData(ar), .fm, .fmParity);

  operandMux opMux (.adaSel(curAdaSel), .adbSel(curAdbSel), .ar, .arx, .br, .brx,
    .mq, .fm, .ada, .adb, .adxa, .adxb);

  // Long add chains the ADX carry into AD for a 72-bit sum
  assign adCarryIn = adChainEn ? adxCarryOut : adxCarryIn;

  lookaheadAlu #(.width(wordBits + 2)) adUnit (.func(curAluFunc), .a({ada[0], ada[0], ada}),
    .b(adb), .carryIn(adCarryIn), .result(adFull), .carryOut, .overflow(adOverflow));

  lookaheadAlu #(.width(wordBits)) adxUnit (.func(curAluFunc), .a(adxa), .b(adxb),
    .carryIn(adxCarryIn), .result(adx), .carryOut(adxCarryOut), .overflow());

  assign adResult = adFull[2:wordBits+1];

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      diagData <= '0;
    end else if (diagRead) begin
      case (diagSel)
        diagAR:  diagData <= ar;
        diagBR:  diagData <= br;
        diagMQ:  diagData <= mq;
        diagFM:  diagData <= fm;
        diagBRX: diagData <= brx;
        diagARX: diagData <= arx;
        diagADX: diagData <= adx;
        default: diagData <= adResult;
      endcase
    end
  end

endmodule

// ==== bench/edpBench.sv ====
`timescale 1ns/1ns

module edpBench;
  import edpPkg::*;

  // One microword worth of control fields
  typedef struct packed {
    adaSelT adaSel;
    adbSelT adbSel;
    aluFuncT aluFunc;
    arSrcT arSrc;
    logic arLoadLeft;
    logic arLoadRight;
    arSrcT arxSrc;
    logic arxLoad;
    logic brLoad;
    logic brxLoad;
    mqFuncT mqFunc;
    logic [shiftCountBits-1:0] shiftCount;
    logic [3:0] fmAddr;
    logic fmWriteLeft;
    logic fmWriteRight;
    logic longAdd;
    logic carryIn;
    diagSelT diagSel;
    logic diagRead;
  } ctlT;

  typedef enum int {chkNone, chkAlu, chkParity, chkShift} checkT;

  logic CLK;
  logic arstN;
  logic execute;
  adaSelT adaSel;
  adbSelT adbSel;
  aluFuncT aluFunc;
  arSrcT arSrc;
  logic arLoadLeft;
  logic arLoadRight;
  arSrcT arxSrc;
  logic arxLoad;
  logic brLoad;
  logic brxLoad;
  mqFuncT mqFunc;
  logic [shiftCountBits-1:0] shiftCount;
  logic [3:0] fmAddr;
  logic fmWriteLeft;
  logic fmWriteRight;
  logic longAdd;
  logic carryIn;
  diagSelT diagSel;
  logic diagRead;
  word cacheData;
  word ebusData;
  word adResult;
  logic adOverflow;
  logic carryOut;
  logic fmParity;
  word diagData;
  logic busy;
  logic done;

  // Stimulus table
  string rowName[$];
  checkT rowCheck[$];
  ctlT rowCtl[$];
  logic [35:0] rowCache[$];
  logic [35:0] rowEbus[$];

  // Reference model state, numbered LSB first
  logic [35:0] mAr, mArx, mBr, mBrx, mMq;
  logic [35:0] mFm [0:15];
  logic [35:0] expAd, expAdx, expDiag;
  logic expCarry, expOvf;

  integer seed = 32'hae64;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycleLimit = 0;

  edpTop #(.fmAddrBits(4)) dut (.CLK, .arstN, .execute, .adaSel, .adbSel, .aluFunc,
    .arSrc, .arLoadLeft, .arLoadRight, .arxSrc, .arxLoad, .brLoad, .brxLoad, .mqFunc,
    .shiftCount, .fmAddr, .fmWriteLeft, .fmWriteRight, .longAdd, .carryIn, .diagSel,
    .diagRead, .cacheData, .ebusData, .adResult, .adOverflow, .carryOut, .fmParity,
    .diagData, .busy, .done);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycleLimit != 0 && cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [35:0] rand36();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[35:0];
  endfunction

  function automatic ctlT idleWord();
    ctlT c;
    c.adaSel = adaZero;
    c.adbSel = adbBR;
    c.aluFunc = aluAdd;
    c.arSrc = arZero;
    c.arLoadLeft = 1'b0;
    c.arLoadRight = 1'b0;
    c.arxSrc = arZero;
    c.arxLoad = 1'b0;
    c.brLoad = 1'b0;
    c.brxLoad = 1'b0;
    c.mqFunc = mqHold;
    c.shiftCount = '0;
    c.fmAddr = '0;
    c.fmWriteLeft = 1'b0;
    c.fmWriteRight = 1'b0;
    c.longAdd = 1'b0;
    c.carryIn = 1'b0;
    c.diagSel = diagAR;
    c.diagRead = 1'b0;
    return c;
  endfunction

  function automatic ctlT loadOp(arSrcT src, logic [1:0] halves, arSrcT xSrc, logic xLoad,
                                 logic [1:0] brCopy);
    ctlT c;
    c = idleWord();
    c.arSrc = src;
    c.arLoadLeft = halves[1];
    c.arLoadRight = halves[0];
    c.arxSrc = xSrc;
    c.arxLoad = xLoad;
    c.brLoad = brCopy[1];
    c.brxLoad = brCopy[0];
    return c;
  endfunction

  function automatic ctlT aluOp(adaSelT a, adbSelT b, aluFuncT f, logic chain, logic cin);
    ctlT c;
    c = idleWord();
    c.adaSel = a;
    c.adbSel = b;
    c.aluFunc = f;
    c.longAdd = chain;
    c.carryIn = cin;
    return c;
  endfunction

  function automatic ctlT fmWrite(logic [3:0] addr, logic [1:0] we);
    ctlT c;
    c = idleWord();
    c.fmAddr = addr;
    c.fmWriteLeft = we[1];
    c.fmWriteRight = we[0];
    return c;
  endfunction

  function automatic ctlT diagOp(diagSelT sel, logic [3:0] addr);
    ctlT c;
    c = idleWord();
    c.diagSel = sel;
    c.fmAddr = addr;
    c.diagRead = 1'b1;
    return c;
  endfunction

  task automatic addRow(string name, checkT chk, ctlT c, logic [35:0] cache,
                        logic [35:0] ebus);
    rowName.push_back(name);
    rowCheck.push_back(chk);
    rowCtl.push_back(c);
    rowCache.push_back(cache);
    rowEbus.push_back(ebus);
  endtask

  // Returns {overflow, carry, result} from the 36-bit function rules
  function automatic logic [37:0] aluRef(aluFuncT f, logic [35:0] a, logic [35:0] b,
                                         logic cin);
    logic [36:0] s;
    logic [35:0] bb;
    logic c;
    logic ovf;
    logic [37:0] r;
    bb = (f == aluSub) ? ~b : b;
    c = (f == aluSub) ? 1'b1 : cin;
    s = {1'b0, a} + {1'b0, bb} + {36'b0, c};
    ovf = (a[35] == bb[35]) && (s[35] != a[35]);
    case (f)
      aluAdd, aluSub: r = {ovf, s[36], s[35:0]};
      aluAnd: r = {2'b00, a & b};
      aluOr: r = {2'b00, a | b};
      aluXor: r = {2'b00, a ^ b};
      aluPassA: r = {2'b00, a};
      aluPassB: r = {2'b00, b};
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic evalAlu(input ctlT c);
    logic [71:0] bx2;
    logic [71:0] ax4;
    logic [35:0] a, b, xa, xb;
    logic [37:0] hi, lo;
    logic adCin;
    bx2 = {mBr, mBrx} << 1;
    ax4 = {mAr, mArx} << 2;
    case (c.adaSel)
      adaAR: a = mAr;
      adaARX: a = mArx;
      adaMQ: a = mMq;
      default: a = '0;
    endcase
    xa = (c.adaSel == adaZero) ? '0 : mArx;
    case (c.adbSel)
      adbFM: begin
        b = mFm[c.fmAddr];
        xb = '0;
      end
      adbBRx2: begin
        b = bx2[71:36];
        xb = bx2[35:0];
      end
      adbBR: begin
        b = mBr;
        xb = mBrx;
      end
      default: begin
        b = ax4[71:36];
        xb = ax4[35:0];
      end
    endcase
    lo = aluRef(c.aluFunc, xa, xb, c.carryIn);
    // Long add takes the low word carry
    adCin = c.longAdd ? lo[36] : c.carryIn;
    hi = aluRef(c.aluFunc, a, b, adCin);
    expAd = hi[35:0];
    expCarry = hi[36];
    expOvf = hi[37];
    expAdx = lo[35:0];
  endtask

  function automatic logic [35:0] pickSource(arSrcT src, ctlT c, logic [35:0] cache,
                                             logic [35:0] ebus);
    logic [35:0] v;
    case (src)
      arCache: v = cache;
      arAD: v = expAd;
      arEbus: v = ebus;
      arADX: v = expAdx;
      arMQ: v = mMq;
      arFM: v = mFm[c.fmAddr];
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic logic [35:0] pickDiag(ctlT c);
    logic [35:0] v;
    case (c.diagSel)
      diagAR: v = mAr;
      diagBR: v = mBr;
      diagMQ: v = mMq;
      diagFM: v = mFm[c.fmAddr];
      diagBRX: v = mBrx;
      diagARX: v = mArx;
      diagADX: v = expAdx;
      default: v = expAd;
    endcase
    return v;
  endfunction

  // Register updates of one accepted microword, all from pre-edge values
  task automatic commitRow(input ctlT c, input logic [35:0] cache, input logic [35:0] ebus);
    logic [35:0] srcAr, srcArx, oldAr, oldArx;
    srcAr = pickSource(c.arSrc, c, cache, ebus);
    srcArx = pickSource(c.arxSrc, c, cache, ebus);
    oldAr = mAr;
    oldArx = mArx;
    if (c.arLoadLeft) mAr[35:18] = srcAr[35:18];
    if (c.arLoadRight) mAr[17:0] = srcAr[17:0];
    if (c.arxLoad) mArx = srcArx;
    if (c.brLoad) mBr = oldAr;
    if (c.brxLoad) mBrx = oldArx;
    if (c.mqFunc == mqLoad) mMq = expAd;
    if (c.fmWriteLeft) mFm[c.fmAddr][35:18] = oldAr[35:18];
    if (c.fmWriteRight) mFm[c.fmAddr][17:0] = oldAr[17:0];
  endtask

  task automatic driveRow(input ctlT c, input logic [35:0] cache, input logic [35:0] ebus,
                          input logic exec);
    execute = exec;
    adaSel = c.adaSel;
    adbSel = c.adbSel;
    aluFunc = c.aluFunc;
    arSrc = c.arSrc;
    arLoadLeft = c.arLoadLeft;
    arLoadRight = c.arLoadRight;
    arxSrc = c.arxSrc;
    arxLoad = c.arxLoad;
    brLoad = c.brLoad;
    brxLoad = c.brxLoad;
    mqFunc = c.mqFunc;
    shiftCount = c.shiftCount;
    fmAddr = c.fmAddr;
    fmWriteLeft = c.fmWriteLeft;
    fmWriteRight = c.fmWriteRight;
    longAdd = c.longAdd;
    carryIn = c.carryIn;
    diagSel = c.diagSel;
    diagRead = c.diagRead;
    cacheData = cache;
    ebusData = ebus;
  endtask

  task automatic checkValue(string name, string what, logic [35:0] exp, logic [35:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  // Starts on the falling edge after the accepting edge
  task automatic runShift(input string name, input ctlT c);
    int busyCycles;
    int donePulses;
    logic [35:0] m;
    ctlT poke;
    busyCycles = 0;
    donePulses = 0;
    poke = loadOp(arCache, 2'b11, arCache, 1'b1, 2'b11);
    poke.mqFunc = mqLoad;
    while (busy === 1'b1) begin
      busyCycles++;
      if (done === 1'b1) donePulses++;
      // A second microword while busy must be dropped
      if (busyCycles == 1) driveRow(poke, ~mAr, ~mArx, 1'b1);
      @(negedge CLK);
      driveRow(idleWord(), '0, '0, 1'b0);
    end
    checkValue(name, "busy cycles", 36'(int'(c.shiftCount)), 36'(busyCycles));
    checkValue(name, "done pulses", 36'd1, 36'(donePulses));
    checkValue(name, "done after busy", 36'd0, {35'b0, done});
    m = mMq;
    for (int k = 0; k < int'(c.shiftCount); k++) begin
      if (c.mqFunc == mqShl) m = {m[34:0], expCarry};
      else m = {m[35:34], m[34:1]};
    end
    mMq = m;
  endtask

  initial begin
    ctlT c;
    aluFuncT f;
    logic [35:0] maxPos;
    maxPos = 36'h7ffffffff;
    mAr = '0;
    mArx = '0;
    mBr = '0;
    mBrx = '0;
    mMq = '0;
    arstN = 1'b0;
    driveRow(idleWord(), '0, '0, 1'b0);

    // Reset values through the diagnostic path
    addRow("rstAR", chkNone, diagOp(diagAR, 4'd0), '0, '0);
    addRow("rstARX", chkNone, diagOp(diagARX, 4'd0), '0, '0);
    addRow("rstBR", chkNone, diagOp(diagBR, 4'd0), '0, '0);
    addRow("rstBRX", chkNone, diagOp(diagBRX, 4'd0), '0, '0);
    addRow("rstMQ", chkNone, diagOp(diagMQ, 4'd0), '0, '0);

    // ALU functions on AR and BR
    addRow("arFromCache", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), rand36(), '0);
    addRow("brCopy", chkNone, loadOp(arZero, 2'b00, arZero, 1'b0, 2'b10), '0, '0);
    addRow("arFromCache2", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), rand36(), '0);
    for (int i = 0; i < 7; i++) begin
      f = aluFuncT'(3'(i));
      addRow($sformatf("%sOnArBr", f.name()), chkAlu, aluOp(adaAR, adbBR, f, 1'b0, 1'b0),
             '0, '0);
    end
    addRow("addCarryIn", chkAlu, aluOp(adaAR, adbBR, aluAdd, 1'b0, 1'b1), '0, '0);
    addRow("arMaxPos", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), maxPos, '0);
    addRow("brMaxPos", chkNone, loadOp(arZero, 2'b00, arZero, 1'b0, 2'b10), '0, '0);
    addRow("addOverflow", chkAlu, aluOp(adaAR, adbBR, aluAdd, 1'b0, 1'b0), '0, '0);
    addRow("arMinNeg", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), ~maxPos, '0);
    addRow("subOverflow", chkAlu, aluOp(adaAR, adbBR, aluSub, 1'b0, 1'b0), '0, '0);
    addRow("arLeftFromEbus", chkNone, loadOp(arEbus, 2'b10, arZero, 1'b0, 2'b00), '0, rand36());
    addRow("arLeftCheck", chkNone, diagOp(diagAR, 4'd0), '0, '0);

    // Fast memory halfword writes
    addRow("fmDataP", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), rand36(), '0);
    addRow("fmWrite3Both", chkNone, fmWrite(4'd3, 2'b11), '0, '0);
    addRow("fmDataQ", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), rand36(), '0);
    addRow("fmWrite3Left", chkNone, fmWrite(4'd3, 2'b10), '0, '0);
    addRow("fmRead3", chkParity, diagOp(diagFM, 4'd3), '0, '0);
    addRow("fmDataR", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), rand36(), '0);
    addRow("fmWrite9Both", chkNone, fmWrite(4'd9, 2'b11), '0, '0);
    addRow("fmDataS", chkNone, loadOp(arCache, 2'b11, arZero, 1'b0, 2'b00), rand36(), '0);
    addRow("fmWrite9Right", chkNone, fmWrite(4'd9, 2'b01), '0, '0);
    addRow("fmRead9", chkParity, diagOp(diagFM, 4'd9), '0, '0);
    c = aluOp(adaAR, adbFM, aluXor, 1'b0, 1'b0);
    c.fmAddr = 4'd9;
    addRow("arXorFm", chkAlu, c, '0, '0);

    // Low words picked so that ADX carries into AD
    addRow("pairOne", chkNone, loadOp(arCache, 2'b11, arEbus, 1'b1, 2'b00), rand36(),
           36'hc00000005);
    addRow("pairOneToBr", chkNone, loadOp(arZero, 2'b00, arZero, 1'b0, 2'b11), '0, '0);
    addRow("pairTwo", chkNone, loadOp(arCache, 2'b11, arEbus, 1'b1, 2'b00), rand36(),
           36'ha00000007);
    c = aluOp(adaAR, adbBR, aluAdd, 1'b1, 1'b0);
    c.diagSel = diagADX;
    c.diagRead = 1'b1;
    addRow("longAdd", chkAlu, c, '0, '0);
    c.carryIn = 1'b1;
    addRow("longAddCarryIn", chkAlu, c, '0, '0);

    // Shifted ADB forms, low word seen on ADX
    c = aluOp(adaZero, adbBRx2, aluPassB, 1'b0, 1'b0);
    c.diagSel = diagADX;
    c.diagRead = 1'b1;
    addRow("brTimesTwo", chkAlu, c, '0, '0);
    c.adbSel = adbARx4;
    addRow("arTimesFour", chkAlu, c, '0, '0);
    addRow("arPlusBrTimesTwo", chkAlu, aluOp(adaAR, adbBRx2, aluAdd, 1'b0, 1'b0), '0, '0);

    // MQ loads and multi-step shifts
    c = aluOp(adaAR, adbBR, aluPassA, 1'b0, 1'b0);
    c.mqFunc = mqLoad;
    addRow("mqFromAd", chkNone, c, '0, '0);
    c = aluOp(adaAR, adbBR, aluAdd, 1'b0, 1'b0);
    c.mqFunc = mqShl;
    c.shiftCount = 6'd5;
    addRow("shiftLeft5", chkShift, c, '0, '0);
    addRow("mqAfterLeft5", chkNone, diagOp(diagMQ, 4'd0), '0, '0);
    addRow("arAfterBusy", chkNone, diagOp(diagAR, 4'd0), '0, '0);
    c = aluOp(adaZero, adbBR, aluPassB, 1'b0, 1'b0);
    c.mqFunc = mqShr;
    c.shiftCount = 6'd3;
    addRow("shiftRight3", chkShift, c, '0, '0);
    addRow("mqAfterRight3", chkNone, diagOp(diagMQ, 4'd0), '0, '0);
    c = aluOp(adaAR, adbBR, aluAdd, 1'b0, 1'b1);
    c.mqFunc = mqShl;
    c.shiftCount = 6'd1;
    addRow("shiftLeft1", chkShift, c, '0, '0);
    addRow("mqAfterLeft1", chkNone, diagOp(diagMQ, 4'd0), '0, '0);

    for (int i = 0; i < rowCtl.size(); i++) begin
      cycleLimit += 1 + int'(rowCtl[i].shiftCount);
    end
    cycleLimit += 50;

    repeat (8) @(posedge CLK);
    @(negedge CLK);
    arstN = 1'b1;
    checkValue("reset", "busy", 36'd0, {35'b0, busy});
    checkValue("reset", "done", 36'd0, {35'b0, done});
    checkValue("reset", "diagData", 36'd0, diagData);

    for (int i = 0; i < rowName.size(); i++) begin
      c = rowCtl[i];
      driveRow(c, rowCache[i], rowEbus[i], 1'b1);
      #10;
      evalAlu(c);
      if (rowCheck[i] == chkAlu) begin
        checkValue(rowName[i], "adResult", expAd, adResult);
        checkValue(rowName[i], "carryOut", {35'b0, expCarry}, {35'b0, carryOut});
        checkValue(rowName[i], "adOverflow", {35'b0, expOvf}, {35'b0, adOverflow});
      end
      if (rowCheck[i] == chkParity) begin
        checkValue(rowName[i], "fmParity", {35'b0, ^mFm[c.fmAddr]}, {35'b0, fmParity});
      end
      if (c.diagRead) expDiag = pickDiag(c);
      commitRow(c, rowCache[i], rowEbus[i]);
      @(posedge CLK);
      @(negedge CLK);
      driveRow(idleWord(), '0, '0, 1'b0);
      if (c.diagRead) checkValue(rowName[i], "diagData", expDiag, diagData);
      if (rowCheck[i] == chkShift) runShift(rowName[i], c);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
source/edpPkg.sv
source/edpControl.sv
source/operandMux.sv
source/lookaheadAlu.sv
source/workRegs.sv
source/mqShifter.sv
source/fastMem.sv
source/edpTop.sv
bench/edpBench.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module edpBench -f sources.f \
  -o edpSim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/edpSim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -qx "Testbench passed" sim.log && exit 0 || exit 1
